/* files.f */
logic/divPkg.sv
logic/divPreproc.sv
logic/divIter.sv
logic/divPostproc.sv
logic/divTop.sv
verif/divChecker.sv
verif/divTb.sv

/* logic/divIter.sv */
/*
  One radix-2 SRT step per cycle on a carry-save residual, d in [1/2,1).
  Digit selection looks at four bits of the shifted residual only.
  The quotient is built by on-the-fly conversion, no carry-propagate add.
*/

`timescale 1ns/1ps

module divIter (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    load,
  input  logic                    step,
  input  divPkg::residualT        initRes,
  input  logic [divPkg::DivN-1:0] divisor,
  output divPkg::residualT        res
);
  import divPkg::*;

  logic [ResW-1:0] ws2;
  logic [ResW-1:0] wc2;
  logic [ResW-1:0] dAl;
  logic [ResW-1:0] dMux;
  logic [ResW-1:0] majBits;
  logic [3:0]      est;
  logic            cin;
  qDigitT          q;
  residualT        nextRes;

  // Residual doubled, both halves of the carry-save pair
  assign ws2 = {res.ws[ResW-2:0], 1'b0};
  assign wc2 = {res.wc[ResW-2:0], 1'b0};

  ////////////////////////////////////////////////////////////
  // Quotient digit selection
  ////////////////////////////////////////////////////////////

  // Estimate of 2w with three integer bits and one fraction bit.
  // Truncating both halves underestimates by less than one.
  assign est = ws2[ResW-1 -: 4] + wc2[ResW-1 -: 4];

  always_comb begin
    if (!est[3]) begin
      q = qPos;
    end else if (est == 4'b1111) begin
      // Estimate of -1/2 lies in the overlap, a zero digit is safe
      q = qZero;
    end else begin
      q = qNeg;
    end
  end

  ////////////////////////////////////////////////////////////
  // Carry-save residual update
  ////////////////////////////////////////////////////////////

  assign dAl = alignDivisor(divisor);

  // A +1 digit subtracts d, done as ~d plus a carry in at the LSB
  always_comb begin
    unique case (q)
      qPos:    dMux = ~dAl;
      qNeg:    dMux = dAl;
      default: dMux = '0;
    endcase
  end

  assign cin     = (q == qPos);
  assign majBits = (ws2 & wc2) | (ws2 & dMux) | (wc2 & dMux);

  always_comb begin
    nextRes.ws = ws2 ^ wc2 ^ dMux;
    // The doubled carry leaves the LSB free for the subtract carry in
    nextRes.wc = {majBits[ResW-2:0], cin};
    // On-the-fly conversion keeps u and um = u - ulp after every digit
    unique case (q)
      qPos: begin
        nextRes.u  = {res.u[DivB-1:0], 1'b1};
        nextRes.um = {res.u[DivB-1:0], 1'b0};
      end
      qNeg: begin
        nextRes.u  = {res.um[DivB-1:0], 1'b1};
        nextRes.um = {res.um[DivB-1:0], 1'b0};
      end
      default: begin
        nextRes.u  = {res.u[DivB-1:0], 1'b0};
        nextRes.um = {res.um[DivB-1:0], 1'b1};
      end
    endcase
  end

  // The first digit is always +1 since w0 > 0, so um may start at zero.
  // Its stale bits are shifted out over the DivB+1 steps.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      res <= '0;
    end else if (load) begin
      res <= initRes;
    end else if (step) begin
      res <= nextRes;
    end
  end

endmodule

/* logic/divPkg.sv */
/*
  Shared widths, enums and structs for the radix-2 SRT significand divider.
  DivB must be at least DivN so the dividend fits the residual unshifted.
*/

package divPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Significand width with the leading one included
  localparam int DivN = 16;
  // The divider runs DivB+1 iterations for DivB quotient fraction bits
  localparam int DivB = 16;
  // Residual is Q3.(DivB+1) with a sign bit, two integer bits of headroom and the fraction
  localparam int ResW = DivB + 4;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Encoded as a two's complement digit so -1 reads as all ones
  typedef enum logic [1:0] {
    qZero = 2'b00,
    qPos  = 2'b01,
    qNeg  = 2'b11
  } qDigitT;

  typedef enum logic [1:0] {
    sIdle,
    sIter,
    sDone
  } divStateT;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [DivN-1:0] x;
    logic [DivN-1:0] d;
  } divOperandsT;

  typedef struct packed {
    logic [ResW-1:0] ws;
    logic [ResW-1:0] wc;
    logic [DivB:0]   u;
    logic [DivB:0]   um;
  } residualT;

  typedef struct packed {
    logic [DivB:0] quot;
    logic          sticky;
  } divResultT;

  // Places the divisor d = D/2 in [1/2,1) on the residual binary point
  function automatic logic [ResW-1:0] alignDivisor(input logic [DivN-1:0] dIn);
    return ResW'(dIn) << (DivB + 1 - DivN);
  endfunction

endpackage

/* logic/divPostproc.sv */
/*
  Final residual handling. A negative residual selects um, and the sticky
  bit reports a nonzero remainder after that correction. Result and done
  are registered on finish and the result holds until the next division.
*/

`timescale 1ns/1ps

module divPostproc (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    finish,
  input  divPkg::residualT        res,
  input  logic [divPkg::DivN-1:0] divisor,
  output divPkg::divResultT       result,
  output logic                    done
);
  import divPkg::*;

  logic [ResW-1:0] wSum;
  logic [ResW-1:0] dAl;
  logic [ResW-1:0] wsF;
  logic [ResW-1:0] wcF;
  logic [ResW-1:0] majBits;
  logic [DivB:0]   quotSel;
  logic            wEq0;
  logic            wfEq0;
  logic            negRes;
  logic            wZero;

  // True when a + b wraps to zero, checked without a carry chain
  function automatic logic sumIsZero(input logic [ResW-1:0] a, input logic [ResW-1:0] b);
    logic [ResW-1:0] orShift;
    orShift = (a | b) << 1;
    return ((a ^ b) == orShift);
  endfunction

  ////////////////////////////////////////////////////////////
  // Zero residual detection
  ////////////////////////////////////////////////////////////

  assign wEq0 = sumIsZero(res.ws, res.wc);

  // Residual plus d, in case the corrected remainder is the zero one
  assign dAl     = alignDivisor(divisor);
  assign majBits = (res.ws & res.wc) | (res.ws & dAl) | (res.wc & dAl);
  assign wsF     = res.ws ^ res.wc ^ dAl;
  assign wcF     = {majBits[ResW-2:0], 1'b0};
  assign wfEq0   = sumIsZero(wsF, wcF);

  // The full add is only here for its sign bit
  assign wSum   = res.ws + res.wc;
  assign negRes = wSum[ResW-1];

  // A residual of exactly -d is an exact quotient of u - ulp
  assign wZero = wEq0 | (negRes & wfEq0);

  ////////////////////////////////////////////////////////////
  // Quotient select and output register
  ////////////////////////////////////////////////////////////

  assign quotSel = negRes ? res.um : res.u;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result <= '0;
      done   <= 1'b0;
    end else begin
      done <= finish;
      if (finish) begin
        result.quot   <= quotSel;
        result.sticky <= ~wZero;
      end
    end
  end

endmodule

/* logic/divPreproc.sv */
/*
  Input stage and sequencer. Operands are captured only on a start seen in
  idle, a start during a division is dropped. The iteration count is fixed
  at DivB+1, there is no early exit on an exact residual.
*/

`timescale 1ns/1ps

module divPreproc (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      start,
  input  divPkg::divOperandsT       operands,
  output logic                      busy,
  output logic                      load,
  output logic                      step,
  output logic                      finish,
  output divPkg::residualT          initRes,
  output logic [divPkg::DivN-1:0]   divisor
);
  import divPkg::*;

  // Counter has to reach DivB, the index of the last step
  localparam int CntW = $clog2(DivB + 1);

  divStateT        state;
  logic [CntW-1:0] iterCnt;
  divOperandsT     opsQ;
  logic            accept;
  logic            lastStep;

  assign accept   = start && (state == sIdle);
  assign lastStep = step && (iterCnt == CntW'(DivB));
  // Busy spans load, all steps, the finish cycle and the done cycle
  assign busy     = (state != sIdle);

  // Operands stay stable until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      opsQ <= operands;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= sIdle;
      load    <= 1'b0;
      step    <= 1'b0;
      finish  <= 1'b0;
      iterCnt <= '0;
    end else begin
      load   <= accept;
      finish <= lastStep;
      unique case (state)
        sIdle: begin
          if (accept) begin
            state   <= sIter;
            iterCnt <= '0;
          end
        end
        sIter: begin
          // The residual is loaded in the load cycle, stepping follows it
          if (load) begin
            step <= 1'b1;
          end else if (lastStep) begin
            step  <= 1'b0;
            state <= sDone;
          end
          if (step) begin
            iterCnt <= iterCnt + 1'b1;
          end
        end
        sDone: begin
          // Stay one more cycle so busy covers the done pulse
          if (!finish) begin
            state <= sIdle;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  // Initial residual w0 = X/4, below d = D/2 so the SRT bound holds
  always_comb begin
    initRes    = '0;
    initRes.ws = ResW'(opsQ.x) << (DivB - DivN);
  end

  assign divisor = opsQ.d;

endmodule

/* logic/divTop.sv */
/*
  Radix-2 SRT divider for normalized significands, both with the top bit set.
  A start in idle launches one division, done follows DivB+3 edges later.
  No special values, exponents or rounding are handled here.
*/

`timescale 1ns/1ps

module divTop (
  input  logic                clk,
  input  logic                arstN,
  input  logic                start,
  input  divPkg::divOperandsT operands,
  output logic                busy,
  output logic                done,
  output divPkg::divResultT   result
);
  import divPkg::*;

  logic            load;
  logic            step;
  logic            finish;
  residualT        initRes;
  residualT        res;
  logic [DivN-1:0] divisor;

  // Capture, sequencing and the initial residual
  divPreproc u_preproc (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .operands (operands),
    .busy     (busy),
    .load     (load),
    .step     (step),
    .finish   (finish),
    .initRes  (initRes),
    .divisor  (divisor)
  );

  // Iterative carry-save recurrence
  divIter u_iter (
    .clk     (clk),
    .arstN   (arstN),
    .load    (load),
    .step    (step),
    .initRes (initRes),
    .divisor (divisor),
    .res     (res)
  );

  // Sign, zero test and the registered result
  divPostproc u_postproc (
    .clk     (clk),
    .arstN   (arstN),
    .finish  (finish),
    .res     (res),
    .divisor (divisor),
    .result  (result),
    .done    (done)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the SRT divider testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f files.f --top-module divTb -Mdir obj_dir -o divSim

./obj_dir/divSim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures, see sim.log"

/* verif/divChecker.sv */
/*
  Watches the divider ports and checks each division against a reference model.
  Assumes one division in flight and samples every signal on the rising edge.
  The model is an integer divide of X*2^DivB by D, with the remainder giving sticky.
*/

`timescale 1ns/1ps

module divChecker (
  input  logic                clk,
  input  logic                arstN,
  input  logic                start,
  input  logic                busy,
  input  logic                done,
  input  divPkg::divOperandsT operands,
  input  divPkg::divResultT   result,
  input  logic [2:0]          testGroup,
  output int                  checkedCnt,
  output int                  errorCnt
);
  import divPkg::*;

  // Start is sampled at edge 0 and done is set on edge DivB+3,
  // so this sampler sees it one edge later
  localparam int DoneLatency = DivB + 4;

  divOperandsT opsQ[$];
  logic [2:0]  grpQ[$];
  int          nChecked = 0;
  int          nErrors = 0;
  int          edgeCnt = 0;
  int          startEdge = 0;
  logic        inFlight = 1'b0;
  logic        doneLast = 1'b0;

  assign checkedCnt = nChecked;
  assign errorCnt   = nErrors;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Truncated quotient of X*2^DivB / D with the integer bit on top
  function automatic divResultT expectedResult(input divOperandsT ops);
    logic [63:0] num;
    logic [63:0] quo;
    logic [63:0] rem;
    divResultT   r;
    num      = 64'(ops.x) << DivB;
    quo      = num / 64'(ops.d);
    rem      = num % 64'(ops.d);
    r.quot   = quo[DivB:0];
    r.sticky = (rem != 64'd0);
    return r;
  endfunction

  function automatic string groupName(input logic [2:0] grp);
    string s;
    case (grp)
      3'd0:    s = "random";
      3'd1:    s = "exact";
      3'd2:    s = "negres";
      3'd3:    s = "busystart";
      default: s = "unknown";
    endcase
    return s;
  endfunction

  ////////////////////////////////////////////////////////////
  // Port monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : watch
    divResultT   exp;
    divOperandsT ops;
    logic [2:0]  grp;
    int          lat;
    edgeCnt = edgeCnt + 1;

    // The first edge is where the flops first see reset, so skip it
    if (edgeCnt > 1) begin
      if (!arstN && (done !== 1'b0 || result !== '0)) begin
        $display("ERROR: done or result not cleared during reset at edge %0d", edgeCnt);
        nErrors++;
      end
      // Busy has to be high exactly while a division is running
      if (busy !== inFlight) begin
        $display("ERROR: busy is %b at edge %0d while inFlight is %b", busy, edgeCnt,
                 inFlight);
        nErrors++;
      end
    end

    if (done === 1'b1) begin
      if (doneLast) begin
        $display("ERROR: done stayed high for more than one cycle at edge %0d", edgeCnt);
        nErrors++;
      end else if (!inFlight) begin
        $display("ERROR: done pulsed at edge %0d with no division started", edgeCnt);
        nErrors++;
      end else begin
        ops = opsQ.pop_front();
        grp = grpQ.pop_front();
        exp = expectedResult(ops);
        lat = edgeCnt - startEdge;
        if (lat != DoneLatency) begin
          $display("CHECK FAILED %s #%0d latency: expected %0d actual %0d",
                   groupName(grp), nChecked, DoneLatency, lat);
          nErrors++;
        end
        if (result !== exp) begin
          $display("CHECK FAILED %s #%0d x=%h d=%h: expected q=%h s=%b actual q=%h s=%b",
                   groupName(grp), nChecked, ops.x, ops.d, exp.quot, exp.sticky,
                   result.quot, result.sticky);
          nErrors++;
        end else if (lat == DoneLatency) begin
          $display("test %s #%0d x=%h d=%h quot=%h sticky=%b ok",
                   groupName(grp), nChecked, ops.x, ops.d, result.quot, result.sticky);
        end
        nChecked++;
        inFlight = 1'b0;
      end
    end

    // The DUT drops a start that arrives with busy high and so does this model
    if (arstN && start === 1'b1 && busy === 1'b0) begin
      opsQ.push_back(operands);
      grpQ.push_back(testGroup);
      startEdge = edgeCnt;
      inFlight  = 1'b1;
    end

    doneLast = (done === 1'b1);
  end

endmodule

/* verif/divTb.sv */
/*
  Testbench top for the SRT divider, runs 200 divisions in four groups.
  Inputs change 1 ns after the rising edge, the checker does all comparing.
  A cycle counter ends the run if the divisions do not complete in time.
*/

`timescale 1ns/1ps

module divTb;
  import divPkg::*;

  localparam int NumRandom     = 150;
  localparam int NumExact      = 20;
  localparam int NumNegRes     = 20;
  localparam int NumBusyStart  = 10;
  localparam int NumTests      = NumRandom + NumExact + NumNegRes + NumBusyStart;
  // A division takes DivB+4 cycles and the next start waits one more
  localparam int TestCycles    = DivB + 5;
  localparam int TimeoutCycles = NumTests * TestCycles + 100;

  logic        clk;
  logic        arstN;
  logic        start;
  logic        busy;
  logic        done;
  divOperandsT operands;
  divResultT   result;
  logic [2:0]  testGroup;
  int          checkedCnt;
  int          errorCnt;
  int          seed = 32'h449f_363d;
  int          cycleCnt = 0;

  divTop u_dut (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .operands (operands),
    .busy     (busy),
    .done     (done),
    .result   (result)
  );

  divChecker u_checker (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .operands   (operands),
    .result     (result),
    .testGroup  (testGroup),
    .checkedCnt (checkedCnt),
    .errorCnt   (errorCnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ends a run that hangs, e.g. when done never arrives
  initial begin : watchdog
    while (cycleCnt < TimeoutCycles) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("Timeout: divisions did not finish within %0d cycles, %0d checked",
             TimeoutCycles, checkedCnt);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Normalized significand, the leading one is forced
  task automatic randomOperand(output logic [DivN-1:0] v);
    logic [31:0] r;
    r          = $random(seed);
    v          = r[DivN-1:0];
    v[DivN-1]  = 1'b1;
  endtask

  // Called 1 ns after an edge, returns 1 ns after the edge following done
  task automatic runDivision(input logic [DivN-1:0] x, input logic [DivN-1:0] d,
                             input logic [2:0] grp, input logic poke);
    logic [DivN-1:0] px;
    logic [DivN-1:0] pd;
    start      = 1'b1;
    operands.x = x;
    operands.d = d;
    testGroup  = grp;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (poke) begin
      // A second start in the middle of the iterations, other operands
      randomOperand(px);
      randomOperand(pd);
      repeat (4) @(posedge clk);
      #1;
      start      = 1'b1;
      operands.x = px;
      operands.d = pd;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    // The FSM returns to idle one edge after done
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [DivN-1:0] x;
    logic [DivN-1:0] d;
    logic [31:0]     r;
    logic [3:0]      off;
    int              k;
    arstN     = 1'b0;
    start     = 1'b0;
    operands  = '0;
    testGroup = 3'd0;
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(posedge clk);
    #1;

    for (k = 0; k < NumRandom; k++) begin
      randomOperand(x);
      randomOperand(d);
      runDivision(x, d, 3'd0, 1'b0);
    end

    // D equal to X, or D a power of two, so the remainder is zero
    for (k = 0; k < NumExact; k++) begin
      randomOperand(x);
      if (k % 2 == 0) begin
        d = x;
      end else begin
        d = {1'b1, {(DivN-1){1'b0}}};
      end
      runDivision(x, d, 3'd1, 1'b0);
    end

    // X just below D, or D at its maximum, ends on a negative residual
    for (k = 0; k < NumNegRes; k++) begin
      if (k % 2 == 0) begin
        randomOperand(d);
        // Keeps X normalized after the small offset is taken off
        d[DivN-2] = 1'b1;
        r         = $random(seed);
        off       = r[3:0];
        x         = d - DivN'(off) - DivN'(1);
      end else begin
        randomOperand(x);
        d = '1;
      end
      runDivision(x, d, 3'd2, 1'b0);
    end

    for (k = 0; k < NumBusyStart; k++) begin
      randomOperand(x);
      randomOperand(d);
      runDivision(x, d, 3'd3, 1'b1);
    end

    repeat (2) @(posedge clk);
    if (checkedCnt != NumTests) begin
      $display("Only %0d of %0d divisions produced a result", checkedCnt, NumTests);
    end
    $display("Summary: %0d of %0d divisions checked, %0d errors", checkedCnt, NumTests,
             errorCnt);
    if (errorCnt == 0 && checkedCnt == NumTests) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
